// ==== rtl/cce_link_pkg.sv ====
// shared widths, types and constants for the engine to mesh bridge
// rtl files use scoped names in their port lists and import the rest
// also holds the block to network word address mapping
package cce_link_pkg;

  localparam int BP_ADDR_WIDTH   = 24;
  localparam int LINK_ADDR_WIDTH = 22;
  localparam int LINK_DATA_WIDTH = 32;
  localparam int BLOCK_WORDS     = 2;
  localparam int BLOCK_WIDTH     = BLOCK_WORDS * LINK_DATA_WIDTH;
  localparam int WORD_BYTES      = LINK_DATA_WIDTH / 8;
  localparam int BLOCK_BYTES     = BLOCK_WORDS * WORD_BYTES;
  localparam int MAX_CREDITS     = 4;
  localparam int CREDIT_WIDTH    = $clog2(MAX_CREDITS + 1);

  typedef logic [BP_ADDR_WIDTH-1:0]       bp_addr_t;
  typedef logic [LINK_ADDR_WIDTH-1:0]     link_addr_t;
  typedef logic [LINK_DATA_WIDTH-1:0]     link_data_t;
  typedef logic [BLOCK_WIDTH-1:0]         block_t;
  typedef logic [$clog2(BLOCK_WORDS)-1:0] word_idx_t;
  typedef logic [CREDIT_WIDTH-1:0]        credit_t;

  localparam word_idx_t LAST_WORD = word_idx_t'(BLOCK_WORDS - 1);

  // management register map
  localparam link_addr_t FREEZE_ADDR = link_addr_t'(0);
  localparam link_addr_t RESET_ADDR  = link_addr_t'(1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_SEND,
    RX_WAIT,
    RX_RESP
  } rx_state_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_SEND,
    TX_RESP
  } tx_state_t;

  // word k of the block holding byte address addr
  function automatic link_addr_t link_word_addr(input bp_addr_t  addr,
                                                input word_idx_t k);
    return link_addr_t'((addr & ~bp_addr_t'(BLOCK_BYTES - 1)) / WORD_BYTES)
           + link_addr_t'(k);
  endfunction

endpackage

// ==== rtl/cce_link_rx.sv ====
// read path of the bridge
// one read command in flight: issues a load per block word, then
// gathers the returned words into a single block data response
`timescale 1ns/100ps

module cce_link_rx (
  input  logic                   bp_clk_i
  , input  logic                 rst_n_i

  , input  cce_link_pkg::bp_addr_t   mem_cmd_addr_i
  , input  logic                     mem_cmd_v_i
  , output logic                     mem_cmd_ready_o

  , output cce_link_pkg::bp_addr_t   mem_data_resp_addr_o
  , output cce_link_pkg::block_t     mem_data_resp_data_o
  , output logic                     mem_data_resp_v_o
  , input  logic                     mem_data_resp_ready_i

  , output cce_link_pkg::link_addr_t rx_pkt_addr_o
  , output logic                     rx_pkt_v_o
  , input  logic                     rx_pkt_yumi_i

  , input  cce_link_pkg::link_data_t ret_data_i
  , input  logic                     ret_v_i
  , output logic                     ret_yumi_o
);

  import cce_link_pkg::*;

  rx_state_t state_q;
  word_idx_t send_idx_q;
  word_idx_t recv_idx_q;
  bp_addr_t  addr_q;
  block_t    block_q;
  logic      ret_take;

  assign mem_cmd_ready_o      = (state_q == RX_IDLE);
  assign rx_pkt_v_o           = (state_q == RX_SEND);
  assign rx_pkt_addr_o        = link_word_addr(addr_q, send_idx_q);
  assign mem_data_resp_v_o    = (state_q == RX_RESP);
  assign mem_data_resp_addr_o = addr_q;
  assign mem_data_resp_data_o = block_q;

  // word 0 may come back while word 1 is still waiting to go out
  assign ret_take   = ret_v_i & ((state_q == RX_SEND) | (state_q == RX_WAIT));
  assign ret_yumi_o = ret_take;

  always_ff @(posedge bp_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= RX_IDLE;
      send_idx_q <= '0;
      recv_idx_q <= '0;
    end else begin
      if (ret_take) begin
        recv_idx_q <= recv_idx_q + 1'b1;
      end
      case (state_q)
        RX_IDLE: begin
          if (mem_cmd_v_i) begin
            send_idx_q <= '0;
            recv_idx_q <= '0;
            state_q    <= RX_SEND;
          end
        end
        RX_SEND: begin
          if (rx_pkt_yumi_i) begin
            if (send_idx_q == LAST_WORD) begin
              state_q <= RX_WAIT;
            end else begin
              send_idx_q <= send_idx_q + 1'b1;
            end
          end
        end
        RX_WAIT: begin
          if (ret_take && (recv_idx_q == LAST_WORD)) begin
            state_q <= RX_RESP;
          end
        end
        RX_RESP: begin
          if (mem_data_resp_ready_i) begin
            state_q <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // returned words land in order, word 0 in the low half
  always_ff @(posedge bp_clk_i) begin
    if (mem_cmd_ready_o && mem_cmd_v_i) begin
      addr_q <= mem_cmd_addr_i;
    end
    if (ret_take) begin
      block_q[recv_idx_q*LINK_DATA_WIDTH +: LINK_DATA_WIDTH] <= ret_data_i;
    end
  end

endmodule

// ==== rtl/cce_link_tx.sv ====
// write path of the bridge
// splits one data command into word stores and acknowledges it
// once the last store has been taken by the network
`timescale 1ns/100ps

module cce_link_tx (
  input  logic                   bp_clk_i
  , input  logic                 rst_n_i

  , input  cce_link_pkg::bp_addr_t   mem_data_cmd_addr_i
  , input  cce_link_pkg::block_t     mem_data_cmd_data_i
  , input  logic                     mem_data_cmd_v_i
  , output logic                     mem_data_cmd_ready_o

  , output cce_link_pkg::bp_addr_t   mem_resp_addr_o
  , output logic                     mem_resp_v_o
  , input  logic                     mem_resp_ready_i

  , output cce_link_pkg::link_addr_t tx_pkt_addr_o
  , output cce_link_pkg::link_data_t tx_pkt_data_o
  , output logic                     tx_pkt_v_o
  , input  logic                     tx_pkt_yumi_i
);

  import cce_link_pkg::*;

  tx_state_t state_q;
  word_idx_t idx_q;
  bp_addr_t  addr_q;
  block_t    block_q;

  assign mem_data_cmd_ready_o = (state_q == TX_IDLE);
  assign tx_pkt_v_o           = (state_q == TX_SEND);
  assign tx_pkt_addr_o        = link_word_addr(addr_q, idx_q);
  assign tx_pkt_data_o        = block_q[idx_q*LINK_DATA_WIDTH +: LINK_DATA_WIDTH];
  assign mem_resp_v_o         = (state_q == TX_RESP);
  assign mem_resp_addr_o      = addr_q;

  always_ff @(posedge bp_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= TX_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (mem_data_cmd_v_i) begin
            idx_q   <= '0;
            state_q <= TX_SEND;
          end
        end
        TX_SEND: begin
          if (tx_pkt_yumi_i) begin
            if (idx_q == LAST_WORD) begin
              state_q <= TX_RESP;
            end else begin
              idx_q <= idx_q + 1'b1;
            end
          end
        end
        TX_RESP: begin
          if (mem_resp_ready_i) begin
            state_q <= TX_IDLE;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge bp_clk_i) begin
    if (mem_data_cmd_ready_o && mem_data_cmd_v_i) begin
      addr_q  <= mem_data_cmd_addr_i;
      block_q <= mem_data_cmd_data_i;
    end
  end

endmodule

// ==== rtl/cce_link_out_arb.sv ====
// shares the network output between the load and store sources
// loads win whenever present; nothing is offered without a credit
`timescale 1ns/100ps

module cce_link_out_arb (
  input  logic                   bp_clk_i
  , input  logic                 rst_n_i

  , input  cce_link_pkg::link_addr_t rx_pkt_addr_i
  , input  logic                     rx_pkt_v_i
  , output logic                     rx_pkt_yumi_o

  , input  cce_link_pkg::link_addr_t tx_pkt_addr_i
  , input  cce_link_pkg::link_data_t tx_pkt_data_i
  , input  logic                     tx_pkt_v_i
  , output logic                     tx_pkt_yumi_o

  , output cce_link_pkg::link_addr_t pkt_addr_o
  , output cce_link_pkg::link_data_t pkt_data_o
  , output logic                     pkt_we_o
  , output logic                     pkt_v_o
  , input  logic                     pkt_ready_i
  , input  logic                     credit_return_i
);

  import cce_link_pkg::*;

  credit_t credits_q;
  logic    has_credit;
  logic    send;

  assign has_credit = (credits_q != '0);

  assign pkt_v_o    = (rx_pkt_v_i | tx_pkt_v_i) & has_credit;
  assign pkt_addr_o = rx_pkt_v_i ? rx_pkt_addr_i : tx_pkt_addr_i;
  // loads carry no payload
  assign pkt_data_o = rx_pkt_v_i ? '0 : tx_pkt_data_i;
  assign pkt_we_o   = ~rx_pkt_v_i & tx_pkt_v_i;

  assign send          = pkt_v_o & pkt_ready_i;
  assign rx_pkt_yumi_o = send & rx_pkt_v_i;
  assign tx_pkt_yumi_o = send & ~rx_pkt_v_i;

  // a send and a return in the same cycle cancel out
  always_ff @(posedge bp_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credits_q <= credit_t'(MAX_CREDITS);
    end else begin
      case ({send, credit_return_i})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

endmodule

// ==== rtl/cce_link_mgmt.sv ====
// freeze and reset control registers for the core
// inbound network requests are always taken at once and answered
// on the returning channel one cycle later, writes return zero
`timescale 1ns/100ps

module cce_link_mgmt (
  input  logic                   bp_clk_i
  , input  logic                 rst_n_i

  , input  logic                     in_v_i
  , input  cce_link_pkg::link_addr_t in_addr_i
  , input  cce_link_pkg::link_data_t in_data_i
  , input  logic                     in_we_i
  , output logic                     in_yumi_o

  , output cce_link_pkg::link_data_t returning_data_o
  , output logic                     returning_v_o

  , output logic                     freeze_o
  , output logic                     reset_o
);

  import cce_link_pkg::*;

  logic       freeze_q;
  logic       reset_q;
  logic       returning_v_q;
  link_data_t returning_data_q;
  link_data_t rd_data;

  assign in_yumi_o        = in_v_i;
  assign returning_v_o    = returning_v_q;
  assign returning_data_o = returning_data_q;
  assign freeze_o         = freeze_q;
  assign reset_o          = reset_q;

  // unmapped addresses read as zero
  always_comb begin
    rd_data = '0;
    if (!in_we_i) begin
      if (in_addr_i == FREEZE_ADDR) begin
        rd_data[0] = freeze_q;
      end else if (in_addr_i == RESET_ADDR) begin
        rd_data[0] = reset_q;
      end
    end
  end

  // core comes out of reset frozen
  always_ff @(posedge bp_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      freeze_q      <= 1'b1;
      reset_q       <= 1'b0;
      returning_v_q <= 1'b0;
    end else begin
      returning_v_q <= in_v_i;
      if (in_v_i && in_we_i && (in_addr_i == FREEZE_ADDR)) begin
        freeze_q <= in_data_i[0];
      end
      if (in_v_i && in_we_i && (in_addr_i == RESET_ADDR)) begin
        reset_q <= in_data_i[0];
      end
    end
  end

  always_ff @(posedge bp_clk_i) begin
    if (in_v_i) begin
      returning_data_q <= rd_data;
    end
  end

endmodule

// ==== rtl/cce_link_bridge.sv ====
// top of the engine to mesh bridge
// engine memory port on one side, network endpoint on the other,
// plus the freeze and reset controls driven from the network
`timescale 1ns/100ps

module cce_link_bridge (
  input  logic                   bp_clk_i
  , input  logic                 rst_n_i

  // engine side
  , input  cce_link_pkg::bp_addr_t   mem_cmd_addr_i
  , input  logic                     mem_cmd_v_i
  , output logic                     mem_cmd_ready_o

  , output cce_link_pkg::bp_addr_t   mem_data_resp_addr_o
  , output cce_link_pkg::block_t     mem_data_resp_data_o
  , output logic                     mem_data_resp_v_o
  , input  logic                     mem_data_resp_ready_i

  , input  cce_link_pkg::bp_addr_t   mem_data_cmd_addr_i
  , input  cce_link_pkg::block_t     mem_data_cmd_data_i
  , input  logic                     mem_data_cmd_v_i
  , output logic                     mem_data_cmd_ready_o

  , output cce_link_pkg::bp_addr_t   mem_resp_addr_o
  , output logic                     mem_resp_v_o
  , input  logic                     mem_resp_ready_i

  // network side
  , output cce_link_pkg::link_addr_t pkt_addr_o
  , output cce_link_pkg::link_data_t pkt_data_o
  , output logic                     pkt_we_o
  , output logic                     pkt_v_o
  , input  logic                     pkt_ready_i
  , input  logic                     credit_return_i

  , input  cce_link_pkg::link_data_t ret_data_i
  , input  logic                     ret_v_i
  , output logic                     ret_yumi_o

  , input  logic                     in_v_i
  , input  cce_link_pkg::link_addr_t in_addr_i
  , input  cce_link_pkg::link_data_t in_data_i
  , input  logic                     in_we_i
  , output logic                     in_yumi_o

  , output cce_link_pkg::link_data_t returning_data_o
  , output logic                     returning_v_o

  , output logic                     freeze_o
  , output logic                     reset_o
);

  import cce_link_pkg::*;

  link_addr_t rx_pkt_addr;
  logic       rx_pkt_v;
  logic       rx_pkt_yumi;
  link_addr_t tx_pkt_addr;
  link_data_t tx_pkt_data;
  logic       tx_pkt_v;
  logic       tx_pkt_yumi;

  cce_link_rx rx_i (
    .*
    , .rx_pkt_addr_o (rx_pkt_addr)
    , .rx_pkt_v_o    (rx_pkt_v)
    , .rx_pkt_yumi_i (rx_pkt_yumi)
  );

  cce_link_tx tx_i (
    .*
    , .tx_pkt_addr_o (tx_pkt_addr)
    , .tx_pkt_data_o (tx_pkt_data)
    , .tx_pkt_v_o    (tx_pkt_v)
    , .tx_pkt_yumi_i (tx_pkt_yumi)
  );

  // single network output, loads first
  cce_link_out_arb out_arb_i (
    .*
    , .rx_pkt_addr_i (rx_pkt_addr)
    , .rx_pkt_v_i    (rx_pkt_v)
    , .rx_pkt_yumi_o (rx_pkt_yumi)
    , .tx_pkt_addr_i (tx_pkt_addr)
    , .tx_pkt_data_i (tx_pkt_data)
    , .tx_pkt_v_i    (tx_pkt_v)
    , .tx_pkt_yumi_o (tx_pkt_yumi)
  );

  cce_link_mgmt mgmt_i (
    .*
  );

endmodule

// ==== verif/cce_link_assertions.sv ====
// handshake and credit properties of the bridge, bound to cce_link_bridge
// error_count is watched by the testbench
`timescale 1ns/100ps

module cce_link_assertions (
  input  logic                   bp_clk_i
  , input  logic                 rst_n_i
  , input  logic                 pkt_v_i
  , input  logic                 pkt_ready_i
  , input  logic                 credit_return_i
  , input  cce_link_pkg::credit_t credits_i
  , input  logic                 mem_data_resp_v_i
  , input  logic                 mem_data_resp_ready_i
  , input  cce_link_pkg::block_t mem_data_resp_data_i
  , input  cce_link_pkg::bp_addr_t mem_data_resp_addr_i
  , input  logic                 mem_resp_v_i
  , input  logic                 mem_resp_ready_i
  , input  cce_link_pkg::bp_addr_t mem_resp_addr_i
  , input  logic                 in_v_i
  , input  logic                 returning_v_i
);

  import cce_link_pkg::*;

  int unsigned error_count = 0;
  int          port_credits;

  // credits rebuilt from the packet and credit return ports
  always_ff @(posedge bp_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      port_credits <= MAX_CREDITS;
    end else begin
      port_credits <= port_credits - int'(pkt_v_i && pkt_ready_i) + int'(credit_return_i);
    end
  end

  no_send_without_credit: assert property (@(posedge bp_clk_i) disable iff (!rst_n_i)
    pkt_v_i |-> (port_credits > 0))
    else begin
      $error("packet offered with no credit left");
      error_count++;
    end

  credits_in_range: assert property (@(posedge bp_clk_i) disable iff (!rst_n_i)
    credits_i <= credit_t'(MAX_CREDITS))
    else begin
      $error("credit counter above its limit");
      error_count++;
    end

  // held response keeps its payload
  data_resp_stable: assert property (@(posedge bp_clk_i) disable iff (!rst_n_i)
    (mem_data_resp_v_i && !mem_data_resp_ready_i) |=>
      (mem_data_resp_v_i && $stable(mem_data_resp_data_i) && $stable(mem_data_resp_addr_i)))
    else begin
      $error("data response changed while stalled");
      error_count++;
    end

  write_ack_stable: assert property (@(posedge bp_clk_i) disable iff (!rst_n_i)
    (mem_resp_v_i && !mem_resp_ready_i) |=> (mem_resp_v_i && $stable(mem_resp_addr_i)))
    else begin
      $error("write acknowledge changed while stalled");
      error_count++;
    end

  returning_follows_request: assert property (@(posedge bp_clk_i) disable iff (!rst_n_i)
    returning_v_i == $past(in_v_i))
    else begin
      $error("returning_v_o does not follow in_v_i by one cycle");
      error_count++;
    end

endmodule

bind cce_link_bridge cce_link_assertions assertions_i (
  .bp_clk_i              (bp_clk_i)
  , .rst_n_i             (rst_n_i)
  , .pkt_v_i             (pkt_v_o)
  , .pkt_ready_i         (pkt_ready_i)
  , .credit_return_i     (credit_return_i)
  , .credits_i           (out_arb_i.credits_q)
  , .mem_data_resp_v_i   (mem_data_resp_v_o)
  , .mem_data_resp_ready_i (mem_data_resp_ready_i)
  , .mem_data_resp_data_i (mem_data_resp_data_o)
  , .mem_data_resp_addr_i (mem_data_resp_addr_o)
  , .mem_resp_v_i        (mem_resp_v_o)
  , .mem_resp_ready_i    (mem_resp_ready_i)
  , .mem_resp_addr_i     (mem_resp_addr_o)
  , .in_v_i              (in_v_i)
  , .returning_v_i       (returning_v_o)
);

// ==== verif/cce_link_tb.sv ====
// testbench for the engine to mesh bridge
// runs the operations listed in verif/cce_link_patterns.txt against the DUT
// and models the network endpoint with a word memory, delayed load returns,
// delayed credit returns and random back-pressure on the output
`timescale 1ns/100ps

module cce_link_tb;

  import cce_link_pkg::*;

  localparam logic [31:0] SEED          = 32'h513850eb;
  localparam int          RESET_CYCLES  = 4;
  localparam int          CYCLES_PER_OP = 200;
  localparam int          MAX_OPS       = 64;
  localparam int          MEM_AW        = 12;

  logic       bp_clk_i;
  logic       rst_n_i;
  bp_addr_t   mem_cmd_addr_i;
  logic       mem_cmd_v_i;
  logic       mem_cmd_ready_o;
  bp_addr_t   mem_data_resp_addr_o;
  block_t     mem_data_resp_data_o;
  logic       mem_data_resp_v_o;
  logic       mem_data_resp_ready_i;
  bp_addr_t   mem_data_cmd_addr_i;
  block_t     mem_data_cmd_data_i;
  logic       mem_data_cmd_v_i;
  logic       mem_data_cmd_ready_o;
  bp_addr_t   mem_resp_addr_o;
  logic       mem_resp_v_o;
  logic       mem_resp_ready_i;
  link_addr_t pkt_addr_o;
  link_data_t pkt_data_o;
  logic       pkt_we_o;
  logic       pkt_v_o;
  logic       pkt_ready_i = 1'b0;
  logic       credit_return_i = 1'b0;
  link_data_t ret_data_i = '0;
  logic       ret_v_i = 1'b0;
  logic       ret_yumi_o;
  logic       in_v_i;
  link_addr_t in_addr_i;
  link_data_t in_data_i;
  logic       in_we_i;
  logic       in_yumi_o;
  link_data_t returning_data_o;
  logic       returning_v_o;
  logic       freeze_o;
  logic       reset_o;

  // pattern table
  string       op_a   [MAX_OPS];
  logic [63:0] addr_a [MAX_OPS];
  logic [63:0] data_a [MAX_OPS];
  logic [63:0] exp_a  [MAX_OPS];
  int          n_ops;

  // network model state
  link_data_t  net_mem [1<<MEM_AW];
  link_data_t  load_data_q [$];
  int          load_due_q [$];
  int          credit_due_q [$];
  int          outstanding;
  int          cycle;
  int          timeout_limit;
  logic [31:0] net_rnd;

  cce_link_bridge dut_i (.*);

  initial begin
    bp_clk_i = 1'b0;
    forever #20 bp_clk_i = ~bp_clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Error in %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  task automatic load_patterns();
    int          fd;
    int          n;
    string       line;
    string       op;
    logic [63:0] a;
    logic [63:0] d;
    logic [63:0] e;
    fd = $fopen("verif/cce_link_patterns.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the pattern file verif/cce_link_patterns.txt");
    end
    n_ops = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%s %h %h %h", op, a, d, e);
        if (n == 4) begin
          if (n_ops == MAX_OPS) begin
            abort_run("the pattern file holds more operations than the table");
          end
          op_a[n_ops]   = op;
          addr_a[n_ops] = a;
          data_a[n_ops] = d;
          exp_a[n_ops]  = e;
          n_ops++;
        end
      end
    end
    $fclose(fd);
    if (n_ops == 0) begin
      abort_run("the pattern file holds no operations");
    end
  endtask

  // word k of a block sits at (byte address with low 3 bits cleared) / 4 + k
  function automatic int word_index(input logic [63:0] addr, input int k);
    return int'((addr & ~64'h7) >> 2) + k;
  endfunction

  task automatic read_block(input string name, input logic [63:0] addr,
                            input logic [63:0] expected, input int hold);
    @(negedge bp_clk_i);
    mem_cmd_addr_i = bp_addr_t'(addr);
    mem_cmd_v_i    = 1'b1;
    do @(posedge bp_clk_i); while (!mem_cmd_ready_o);
    @(negedge bp_clk_i);
    mem_cmd_v_i = 1'b0;
    repeat (hold) @(negedge bp_clk_i);
    mem_data_resp_ready_i = 1'b1;
    do @(posedge bp_clk_i); while (!mem_data_resp_v_o);
    check_value({name, " data"}, expected, mem_data_resp_data_o);
    check_value({name, " addr"}, addr, mem_data_resp_addr_o);
    @(negedge bp_clk_i);
    mem_data_resp_ready_i = 1'b0;
  endtask

  task automatic write_block(input string name, input logic [63:0] addr,
                             input logic [63:0] data, input logic [63:0] expected,
                             input int hold);
    @(negedge bp_clk_i);
    mem_data_cmd_addr_i = bp_addr_t'(addr);
    mem_data_cmd_data_i = data;
    mem_data_cmd_v_i    = 1'b1;
    do @(posedge bp_clk_i); while (!mem_data_cmd_ready_o);
    @(negedge bp_clk_i);
    mem_data_cmd_v_i = 1'b0;
    repeat (hold) @(negedge bp_clk_i);
    mem_resp_ready_i = 1'b1;
    do @(posedge bp_clk_i); while (!mem_resp_v_o);
    check_value({name, " ack addr"}, expected, mem_resp_addr_o);
    check_value({name, " word 0"}, data[31:0], net_mem[word_index(addr, 0)]);
    check_value({name, " word 1"}, data[63:32], net_mem[word_index(addr, 1)]);
    @(negedge bp_clk_i);
    mem_resp_ready_i = 1'b0;
  endtask

  task automatic mgmt_access(input string name, input logic we, input logic [63:0] addr,
                             input logic [63:0] data, input logic [63:0] expected);
    @(negedge bp_clk_i);
    in_v_i    = 1'b1;
    in_we_i   = we;
    in_addr_i = link_addr_t'(addr);
    in_data_i = link_data_t'(data);
    @(posedge bp_clk_i);
    check_value({name, " in_yumi_o"}, 1, in_yumi_o);
    @(negedge bp_clk_i);
    in_v_i  = 1'b0;
    in_we_i = 1'b0;
    @(posedge bp_clk_i);
    check_value({name, " returning_v_o"}, 1, returning_v_o);
    check_value({name, " returning_data_o"}, we ? 64'h0 : expected, returning_data_o);
    if (we && addr == FREEZE_ADDR) begin
      check_value({name, " freeze_o"}, expected, freeze_o);
    end else if (we && addr == RESET_ADDR) begin
      check_value({name, " reset_o"}, expected, reset_o);
    end
  endtask

  // network model takes packets and schedules load returns and credits
  always @(posedge bp_clk_i) begin
    int due;
    cycle++;
    if (timeout_limit > 0 && cycle > timeout_limit) begin
      abort_run($sformatf("timeout, the run did not finish within %0d cycles", timeout_limit));
    end
    if (dut_i.assertions_i.error_count != 0) begin
      abort_run("a bound assertion on the bridge failed");
    end
    if (rst_n_i) begin
      if (credit_return_i) begin
        outstanding--;
      end
      if (ret_v_i && ret_yumi_o) begin
        void'(load_data_q.pop_front());
        void'(load_due_q.pop_front());
      end
      if (pkt_v_o && pkt_ready_i) begin
        if ((pkt_addr_o >> MEM_AW) != 0) begin
          abort_run("the DUT sent a packet beyond the network model memory");
        end
        if (pkt_we_o) begin
          net_mem[pkt_addr_o[MEM_AW-1:0]] = pkt_data_o;
        end else begin
          net_rnd = xorshift32(net_rnd);
          due = cycle + 1 + int'(net_rnd % 3);
          if (load_due_q.size() > 0 && due <= load_due_q[$]) begin
            due = load_due_q[$] + 1;
          end
          load_data_q.push_back(net_mem[pkt_addr_o[MEM_AW-1:0]]);
          load_due_q.push_back(due);
        end
        // slow credits so that the bridge runs out of them
        net_rnd = xorshift32(net_rnd);
        due = cycle + 4 + int'(net_rnd % 12);
        if (credit_due_q.size() > 0 && due <= credit_due_q[$]) begin
          due = credit_due_q[$] + 1;
        end
        credit_due_q.push_back(due);
        outstanding++;
      end
      if (outstanding > MAX_CREDITS) begin
        abort_run("more packets are outstanding on the network than there are credits");
      end
    end
  end

  always @(negedge bp_clk_i) begin
    if (rst_n_i) begin
      net_rnd     = xorshift32(net_rnd);
      pkt_ready_i = (net_rnd[1:0] != 2'b00);
      credit_return_i = 1'b0;
      if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle) begin
        credit_return_i = 1'b1;
        void'(credit_due_q.pop_front());
      end
      ret_v_i    = (load_due_q.size() > 0 && load_due_q[0] <= cycle);
      ret_data_i = ret_v_i ? load_data_q[0] : '0;
    end
  end

  initial begin
    string name;
    rst_n_i               = 1'b0;
    mem_cmd_addr_i        = '0;
    mem_cmd_v_i           = 1'b0;
    mem_data_resp_ready_i = 1'b0;
    mem_data_cmd_addr_i   = '0;
    mem_data_cmd_data_i   = '0;
    mem_data_cmd_v_i      = 1'b0;
    mem_resp_ready_i      = 1'b0;
    in_v_i                = 1'b0;
    in_addr_i             = '0;
    in_data_i             = '0;
    in_we_i               = 1'b0;
    cycle                 = 0;
    outstanding           = 0;
    timeout_limit         = 0;
    net_rnd               = SEED;
    for (int i = 0; i < (1 << MEM_AW); i++) begin
      net_mem[i] = 32'h6b00_0000 ^ (i * 32'h9e37_79b1);
    end
    load_patterns();
    timeout_limit = RESET_CYCLES + 4 + CYCLES_PER_OP * n_ops;
    repeat (RESET_CYCLES) @(negedge bp_clk_i);
    rst_n_i = 1'b1;

    @(posedge bp_clk_i);
    check_value("reset freeze_o", 1, freeze_o);
    check_value("reset reset_o", 0, reset_o);
    check_value("reset mem_data_resp_v_o", 0, mem_data_resp_v_o);
    check_value("reset mem_resp_v_o", 0, mem_resp_v_o);
    check_value("reset pkt_v_o", 0, pkt_v_o);
    check_value("reset returning_v_o", 0, returning_v_o);
    check_value("reset mem_cmd_ready_o", 1, mem_cmd_ready_o);
    check_value("reset mem_data_cmd_ready_o", 1, mem_data_cmd_ready_o);

    for (int i = 0; i < n_ops; i++) begin
      name = $sformatf("line %0d %s", i, op_a[i]);
      if (op_a[i] == "READ") begin
        read_block(name, addr_a[i], exp_a[i], i % 3);
      end else if (op_a[i] == "WRITE") begin
        write_block(name, addr_a[i], data_a[i], exp_a[i], i % 3);
      end else if (op_a[i] == "MGMT_WR") begin
        mgmt_access(name, 1'b1, addr_a[i], data_a[i], exp_a[i]);
      end else if (op_a[i] == "MGMT_RD") begin
        mgmt_access(name, 1'b0, addr_a[i], data_a[i], exp_a[i]);
      end else begin
        abort_run($sformatf("unknown opcode %s in the pattern file", op_a[i]));
      end
    end

    repeat (4) @(negedge bp_clk_i);
    if (dut_i.assertions_i.error_count != 0) begin
      abort_run("a bound assertion on the bridge failed");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

// ==== verif/cce_link_patterns.txt ====
# opcode  address  data (hex)        expected (hex)
# READ expects the block, WRITE the ack address, MGMT_WR the register bit, MGMT_RD the read data
MGMT_RD   000000   0000000000000000  0000000000000001
MGMT_RD   000001   0000000000000000  0000000000000000
MGMT_WR   000000   0000000000000000  0000000000000000
MGMT_RD   000000   0000000000000000  0000000000000000
MGMT_WR   000001   0000000000000001  0000000000000001
MGMT_RD   000001   0000000000000000  0000000000000001
MGMT_WR   000001   0000000000000000  0000000000000000
MGMT_RD   000005   0000000000000000  0000000000000000
WRITE     000040   1122334455667788  0000000000000040
WRITE     000048   0123456789abcdef  0000000000000048
READ      000040   0000000000000000  1122334455667788
READ      00004c   0000000000000000  0123456789abcdef
WRITE     001234   deadbeefcafef00d  0000000000001234
WRITE     003ff8   a5a5a5a55a5a5a5a  0000000000003ff8
READ      001230   0000000000000000  deadbeefcafef00d
READ      003ffc   0000000000000000  a5a5a5a55a5a5a5a
WRITE     000040   fedcba9876543210  0000000000000040
READ      000044   0000000000000000  fedcba9876543210
READ      000048   0000000000000000  0123456789abcdef
MGMT_WR   000000   0000000000000001  0000000000000001

// ==== verilog.f ====
rtl/cce_link_pkg.sv
rtl/cce_link_rx.sv
rtl/cce_link_tx.sv
rtl/cce_link_out_arb.sv
rtl/cce_link_mgmt.sv
rtl/cce_link_bridge.sv
verif/cce_link_assertions.sv
verif/cce_link_tb.sv
